/* Bender.yml */
package:
  name: tx_serializer

sources:
  - tx_pkg.sv
  - tx_clock_divider.sv
  - tx_word_source.sv
  - tx_hr_mux.sv
  - tx_qr_mux.sv
  - tx_output_driver.sv
  - tx_top.sv
  - target: test
    files:
      - tb_tx_top.sv

/* flist.f */
tx_pkg.sv
tx_clock_divider.sv
tx_word_source.sv
tx_hr_mux.sv
tx_qr_mux.sv
tx_output_driver.sv
tx_top.sv
tb_tx_top.sv

/* tb_tx_top.sv */
`timescale 1ns/10ps

module tb_tx_top import tx_pkg::*; ();

    // Expected level of both legs for one bit clock
    typedef struct packed {
        logic p;
        logic n;
    } line_t;

    localparam int unsigned num_words    = 150;
    localparam int unsigned sync_timeout = 4 * word_width;  // Clocks to the first rise

    logic                  mdll_clk = 1'b0;
    logic                  arst_n;
    logic [word_width-1:0] din;
    tx_ctl_t               ctl;
    logic                  ctl_valid;
    logic                  clk_prbsgen;
    logic                  dout_p;
    logic                  dout_n;

    // Reference serializer state
    tx_ctl_t               pend;         // Waits for the next word boundary
    logic [prbs_order-1:0] prbs_st;
    line_t                 exp_q[$];     // One entry per bit clock, oldest first
    line_t                 exp_line;     // Line value after the last rising edge
    logic                  exp_prbsgen;
    logic                  synced;       // Word boundary found
    int unsigned           pos;          // Clocks since the last word_load edge
    int unsigned           wait_cnt;
    int unsigned           errors;
    int unsigned           checks;
    int unsigned           words;
    int unsigned           prbs_words;
    int unsigned           idle_words;
    int unsigned           inv_words;

    always #50 mdll_clk = ~mdll_clk;  // 100 ns bit clock

    tx_top i_dut (
        .mdll_clk   (mdll_clk),
        .arst_n     (arst_n),
        .din        (din),
        .ctl        (ctl),
        .ctl_valid  (ctl_valid),
        .clk_prbsgen(clk_prbsgen),
        .dout_p     (dout_p),
        .dout_n     (dout_n)
    );

    // x^15 + x^14 + 1, feedback bit is the bit sent
    task automatic advance_prbs(output logic b);
        b       = prbs_st[prbs_order-1] ^ prbs_st[prbs_order-2];
        prbs_st = {prbs_st[prbs_order-2:0], b};
    endtask

    // Word taken at a word_load edge, queued MSB first
    task automatic load_word();
        tx_ctl_t               act;
        logic [word_width-1:0] data;
        logic                  b;
        line_t                 ln;
        int                    i;
        act = pend;  // Pending control becomes active with this word
        if (act.prbs_restart) begin
            prbs_st = prbs_seed;
        end
        if (act.use_prbs) begin
            for (i = word_width - 1; i >= 0; i--) begin
                advance_prbs(b);
                data[i] = b;
            end
        end else begin
            data = din;
        end
        for (i = word_width - 1; i >= 0; i--) begin
            ln.p = act.idle ? 1'b0 : data[i] ^ act.invert;
            ln.n = act.idle ? 1'b0 : ~ln.p;  // Both low in idle
            exp_q.push_back(ln);
        end
        words++;
        prbs_words += act.use_prbs;
        idle_words += act.idle;
        inv_words  += act.invert & ~act.idle;
    endtask

    // ctl as the DUT samples it at this edge
    task automatic sample_ctl(input logic at_word);
        if (ctl_valid) begin
            pend = ctl;  // Later write wins
        end else if (at_word) begin
            pend.prbs_restart = 1'b0;  // Used up by this word
        end
    endtask

    function automatic tx_ctl_t random_ctl();
        tx_ctl_t c;
        c.use_prbs     = ($urandom % 2) == 1;
        c.invert       = ($urandom % 2) == 1;
        c.idle         = ($urandom % 6) == 0;  // Mostly live words
        c.prbs_restart = ($urandom % 4) == 0;
        return c;
    endfunction

    task automatic run_traffic();
        int unsigned cyc;
        for (cyc = 0; cyc < num_words * word_width; cyc++) begin
            @(posedge mdll_clk);
            pos         = (pos + 1) % word_width;
            exp_prbsgen = pos < word_width / 2;  // High 8 of 16
            if (pos == 0) begin
                load_word();  // word_load edge
            end
            sample_ctl(pos == 0);
            exp_line = exp_q.pop_front();
            if (pos == 1) begin
                din <= word_width'($urandom);  // Right after the clk_prbsgen rise
            end
            if (($urandom % 10) == 0) begin
                ctl       <= random_ctl();
                ctl_valid <= 1'b1;
            end else begin
                ctl_valid <= 1'b0;
            end
        end
    endtask

    // Mid-cycle compare, all DUT outputs settled
    always @(negedge mdll_clk) begin
        checks++;
        assert (dout_p === exp_line.p) else begin
            errors++;
            $display("error at %0t ns: dout_p expected %b, actual %b", $time, exp_line.p, dout_p);
        end
        assert (dout_n === exp_line.n) else begin
            errors++;
            $display("error at %0t ns: dout_n expected %b, actual %b", $time, exp_line.n, dout_n);
        end
        if (synced || !arst_n) begin  // Low through reset, then one rise per word
            assert (clk_prbsgen === exp_prbsgen) else begin
                errors++;
                $display("error at %0t ns: clk_prbsgen expected %b, actual %b",
                         $time, exp_prbsgen, clk_prbsgen);
            end
        end
    end

    initial begin
        void'($urandom(32'haa94a011));
        arst_n      = 1'b0;
        din         = word_width'($urandom);  // First word, captured before the first rise
        ctl         = '0;
        ctl_valid   = 1'b0;
        pend        = '0;
        prbs_st     = prbs_seed;
        exp_line    = line_t'(0);  // Idle out of reset
        exp_prbsgen = 1'b0;
        synced      = 1'b0;
        pos         = 0;
        errors      = 0;
        checks      = 0;
        words       = 0;
        prbs_words  = 0;
        idle_words  = 0;
        inv_words   = 0;
        repeat (5) @(posedge mdll_clk);
        arst_n <= 1'b1;
        wait_cnt = 0;
        while (!synced && wait_cnt < sync_timeout) begin
            @(negedge mdll_clk);
            wait_cnt++;
            if (clk_prbsgen) begin
                // word_load edge just passed, one latency clock already spent
                repeat (tx_latency - 1) exp_q.push_back(line_t'(0));
                load_word();
                exp_prbsgen = 1'b1;
                synced      = 1'b1;
            end
        end
        if (!synced) begin
            errors++;
            $display("timeout: clk_prbsgen did not rise within %0d clocks after reset",
                     sync_timeout);
        end else begin
            run_traffic();
            assert (prbs_words > 0 && prbs_words < words && idle_words > 0 && inv_words > 0)
            else begin
                errors++;
                $display("random control did not reach PRBS, din, idle and inverted words");
            end
        end
        $display("words %0d (prbs %0d, idle %0d, inverted %0d), checks %0d, errors %0d",
                 words, prbs_words, idle_words, inv_words, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tx_clock_divider.sv */
`timescale 1ns/10ps

`default_nettype none

module tx_clock_divider import tx_pkg::*; (
    input  wire logic                   mdll_clk,
    input  wire logic                   arst_n,
    output logic      [phase_width-1:0] phase,       // Quarter-rate phase
    output logic                        nibble_load, // Phase 3
    output logic                        word_load,   // Last bit of a word
    output logic                        clk_prbsgen  // Word-rate clock to the data source
);

    // Bit counter stands in for the div-by-2 chain
    logic [bit_cnt_width-1:0] bit_cnt_q;
    logic [bit_cnt_width-1:0] bit_cnt_nxt;
    logic                     run_q;        // Set after the first word boundary
    logic                     clk_prbsgen_q;

    assign bit_cnt_nxt = bit_cnt_q + 1'b1;  // Wraps every word

    // Low bits give the phase, shifted so phase 3 lands one bit after a word starts
    assign phase = bit_cnt_q[phase_width-1:0] + phase_width'(phase_offset);

    assign nibble_load = &phase;
    assign word_load   = &bit_cnt_q;  // Count 15

    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt_q <= '0;
        end else begin
            bit_cnt_q <= bit_cnt_nxt;
        end
    end

    // Top bit of the next count, registered
    // High for counts 0..7, held low until the first word boundary
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q         <= 1'b0;
            clk_prbsgen_q <= 1'b0;
        end else begin
            run_q         <= run_q | word_load;
            clk_prbsgen_q <= (run_q | word_load) & ~bit_cnt_nxt[bit_cnt_width-1];
        end
    end

    assign clk_prbsgen = clk_prbsgen_q;  // Rises the cycle after word_load

endmodule

`default_nettype wire

/* tx_hr_mux.sv */
`timescale 1ns/10ps

`default_nettype none

module tx_hr_mux import tx_pkg::*; (
    input  wire logic                    mdll_clk,
    input  wire logic                    arst_n,
    input  wire logic                    word_load,
    input  wire logic                    nibble_load,  // Phase 3
    input  wire tx_word_t                word,
    output logic      [nibble_width-1:0] nibble,
    output logic                         nibble_idle
);

    logic                  load_q;   // One clock after word_load
    logic [word_width-1:0] shift_q;  // Reordered word, nibble 0 in the low bits
    logic                  idle_q;

    // Word register settles at the word_load edge, take it one clock later
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            load_q <= 1'b0;
            idle_q <= 1'b1;
        end else begin
            load_q <= word_load;
            if (load_q) begin
                idle_q <= word.idle;  // Whole word shares one flag
            end
        end
    end

    // 16-to-4 stage
    // Load wins over shift, the two never meet with the current phase offset
    always_ff @(posedge mdll_clk) begin
        if (load_q) begin
            shift_q <= hr_reorder(word.data);
        end else if (nibble_load) begin
            shift_q <= shift_q >> nibble_width;  // Next nibble down
        end
    end

    // Current nibble, bit 3 is the earliest
    assign nibble      = shift_q[nibble_width-1:0];
    assign nibble_idle = idle_q;

endmodule

`default_nettype wire

/* tx_output_driver.sv */
`timescale 1ns/10ps

`default_nettype none

module tx_output_driver (
    input  wire logic mdll_clk,
    input  wire logic arst_n,
    input  wire logic serial_bit,
    input  wire logic serial_idle,
    input  wire logic invert,      // Word-aligned polarity
    output logic      dout_p,
    output logic      dout_n
);

    logic line_bit;

    assign line_bit = serial_bit ^ invert;

    // Differential pair from one bit, complement on the n leg
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            dout_p <= 1'b0;  // Idle out of reset
            dout_n <= 1'b0;
        end else if (serial_idle) begin
            dout_p <= 1'b0;  // Electrical idle
            dout_n <= 1'b0;
        end else begin
            dout_p <= line_bit;
            dout_n <= ~line_bit;
        end
    end

endmodule

`default_nettype wire

/* tx_pkg.sv */
package tx_pkg;

    // Datapath widths
    localparam int unsigned word_width   = 16;
    localparam int unsigned nibble_width = 4;
    localparam int unsigned phase_width  = $clog2(nibble_width);  // Quarter-rate phase bits
    localparam int unsigned bit_cnt_width = $clog2(word_width);   // Bit position in a word

    // Phase runs two ahead of the bit position
    // so the qr holding register loads right after nibble 0 shows up
    localparam int unsigned phase_offset = 2;

    // Bit clocks from the word_load edge to the first bit on dout_p
    localparam int unsigned tx_latency = 4;

    // PRBS-15, x^15 + x^14 + 1
    localparam int unsigned prbs_order = 15;
    localparam int unsigned prbs_tap_hi = 14;  // x^15 term
    localparam int unsigned prbs_tap_lo = 13;  // x^14 term
    localparam logic [prbs_order-1:0] prbs_seed = 15'h7fff;

    // Line control, written by ctl_valid
    typedef struct packed {
        logic use_prbs;      // PRBS instead of din
        logic invert;        // Swap p/n
        logic idle;          // Electrical idle, both legs low
        logic prbs_restart;  // Reload seed at next word
    } tx_ctl_t;

    // Captured word plus its idle flag
    typedef struct packed {
        logic [word_width-1:0] data;
        logic                  idle;
    } tx_word_t;

    // Bit 15 goes out first
    // Nibble k of the shift holder carries data[15-4k -: 4], nibble 0 in the low bits
    function automatic logic [word_width-1:0] hr_reorder(input logic [word_width-1:0] data);
        logic [word_width-1:0] holder;
        for (int k = 0; k < word_width / nibble_width; k++) begin
            holder[k*nibble_width +: nibble_width] = data[word_width-1-k*nibble_width -: nibble_width];
        end
        return holder;
    endfunction

endpackage

/* tx_qr_mux.sv */
`timescale 1ns/10ps

`default_nettype none

module tx_qr_mux import tx_pkg::*; (
    input  wire logic                    mdll_clk,
    input  wire logic                    arst_n,
    input  wire logic [phase_width-1:0]  phase,
    input  wire logic [nibble_width-1:0] nibble,
    input  wire logic                    nibble_idle,
    output logic                         serial_bit,
    output logic                         serial_idle
);

    logic [nibble_width-1:0] hold_q;       // Stable for four bit clocks
    logic                    hold_idle_q;
    logic                    hold_load;

    assign hold_load = &phase;  // Phase 3 boundary

    // Nibble from the hr stage may change freely once captured here
    always_ff @(posedge mdll_clk) begin
        if (hold_load) begin
            hold_q <= nibble;
        end
    end

    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_idle_q <= 1'b1;
            serial_bit  <= 1'b0;
            serial_idle <= 1'b1;
        end else begin
            if (hold_load) begin
                hold_idle_q <= nibble_idle;
            end
            // 4-to-1 select, phase 0 takes bit 3
            serial_bit  <= hold_q[nibble_width-1-phase];
            serial_idle <= hold_idle_q;  // Same cycle as the bit
        end
    end

endmodule

`default_nettype wire

/* tx_top.sv */
`timescale 1ns/10ps

`default_nettype none

// Word sampled at a word_load edge shows bit 15 on dout_p tx_latency clocks later
// Source 1, hr mux 1, qr hold plus select 1, driver 1
module tx_top import tx_pkg::*; (
    input  wire logic                  mdll_clk,    // Bit-rate clock from the MDLL
    input  wire logic                  arst_n,
    input  wire logic [word_width-1:0] din,
    input  wire tx_ctl_t               ctl,
    input  wire logic                  ctl_valid,
    output logic                       clk_prbsgen, // Word clock back to the data source
    output logic                       dout_p,
    output logic                       dout_n
);

    logic [phase_width-1:0]  phase;
    logic                    nibble_load;
    logic                    word_load;
    tx_word_t                word;
    logic                    invert;
    logic [nibble_width-1:0] nibble;
    logic                    nibble_idle;
    logic                    serial_bit;
    logic                    serial_idle;

    tx_clock_divider i_div (
        .mdll_clk   (mdll_clk),
        .arst_n     (arst_n),
        .phase      (phase),
        .nibble_load(nibble_load),
        .word_load  (word_load),
        .clk_prbsgen(clk_prbsgen)
    );

    tx_word_source i_src (
        .mdll_clk (mdll_clk),
        .arst_n   (arst_n),
        .word_load(word_load),
        .din      (din),
        .ctl      (ctl),
        .ctl_valid(ctl_valid),
        .word     (word),
        .invert   (invert)
    );

    tx_hr_mux i_hr_mux (
        .mdll_clk   (mdll_clk),
        .arst_n     (arst_n),
        .word_load  (word_load),
        .nibble_load(nibble_load),
        .word       (word),
        .nibble     (nibble),
        .nibble_idle(nibble_idle)
    );

    tx_qr_mux i_qr_mux (
        .mdll_clk   (mdll_clk),
        .arst_n     (arst_n),
        .phase      (phase),
        .nibble     (nibble),
        .nibble_idle(nibble_idle),
        .serial_bit (serial_bit),
        .serial_idle(serial_idle)
    );

    tx_output_driver i_drv (
        .mdll_clk   (mdll_clk),
        .arst_n     (arst_n),
        .serial_bit (serial_bit),
        .serial_idle(serial_idle),
        .invert     (invert),
        .dout_p     (dout_p),
        .dout_n     (dout_n)
    );

endmodule

`default_nettype wire

/* tx_word_source.sv */
`timescale 1ns/10ps

`default_nettype none

module tx_word_source import tx_pkg::*; (
    input  wire logic                  mdll_clk,
    input  wire logic                  arst_n,
    input  wire logic                  word_load,
    input  wire logic [word_width-1:0] din,       // Sampled only at word_load
    input  wire tx_ctl_t               ctl,
    input  wire logic                  ctl_valid,
    output tx_word_t                   word,      // Valid the cycle after word_load
    output logic                       invert     // Aligned to the first bit at the driver
);

    tx_ctl_t                 ctl_pend_q;   // Waiting for the next word
    tx_ctl_t                 ctl_act_q;    // Applies to the word in flight
    logic [prbs_order-1:0]   prbs_q;
    logic [prbs_order-1:0]   prbs_base;
    logic [prbs_order-1:0]   prbs_nxt;     // State after 16 steps
    logic [word_width-1:0]   prbs_word;
    logic [word_width-1:0]   word_data_q;
    logic                    word_idle_q;
    logic [tx_latency-2:0]   load_pipe_q;  // word_load delayed toward the driver
    logic                    invert_q;

    // 16 LFSR steps in one cycle, first bit out lands in data[15]
    always_comb begin
        prbs_base = ctl_pend_q.prbs_restart ? prbs_seed : prbs_q;
        prbs_nxt  = prbs_base;
        for (int i = 0; i < word_width; i++) begin
            prbs_word[word_width-1-i] = prbs_nxt[prbs_tap_hi] ^ prbs_nxt[prbs_tap_lo];
            prbs_nxt = {prbs_nxt[prbs_order-2:0], prbs_word[word_width-1-i]};
        end
    end

    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            ctl_pend_q  <= '0;
            ctl_act_q   <= '0;
            prbs_q      <= prbs_seed;
            word_idle_q <= 1'b1;  // Line idle until the first word
            load_pipe_q <= '0;
            invert_q    <= 1'b0;
        end else begin
            if (ctl_valid) begin
                ctl_pend_q <= ctl;  // Later write wins
            end else if (word_load) begin
                ctl_pend_q.prbs_restart <= 1'b0;  // One-shot
            end
            if (word_load) begin
                ctl_act_q   <= ctl_pend_q;
                word_idle_q <= ctl_pend_q.idle;
                if (ctl_pend_q.use_prbs) begin
                    prbs_q <= prbs_nxt;  // Advance only when used
                end else if (ctl_pend_q.prbs_restart) begin
                    prbs_q <= prbs_seed;
                end
            end
            load_pipe_q <= {load_pipe_q[tx_latency-3:0], word_load};
            // Switch polarity just before the new word's first bit is registered
            if (load_pipe_q[tx_latency-2]) begin
                invert_q <= ctl_act_q.invert;
            end
        end
    end

    always_ff @(posedge mdll_clk) begin
        if (word_load) begin
            word_data_q <= ctl_pend_q.use_prbs ? prbs_word : din;
        end
    end

    assign word   = '{data: word_data_q, idle: word_idle_q};
    assign invert = invert_q;

endmodule

`default_nettype wire
